/* source/rayCorePkg.sv */
// ray core widths, scene limits, light setup and the payload types between stages
package rayCorePkg;

    // --------------------
    // widths and scene limits
    localparam int CoordWidth     = 8;
    localparam int DepthWidth     = 8;
    localparam int MaxPrimitives  = 16;
    localparam int PrimIndexWidth = 4;
    // one bit more so a full scene of 16 fits
    localparam int PrimCountWidth = PrimIndexWidth + 1;
    localparam int LaneCount      = 2;
    localparam int GroupAddrWidth = 3;

    // shadow probe offset, sum wraps in CoordWidth
    localparam logic [CoordWidth-1:0] LightDx = 8'd3;
    localparam logic [CoordWidth-1:0] LightDy = 8'd2;

    // --------------------
    // payload types
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } Rgb8;

    // background for pixels with no hit
    localparam Rgb8 ClearColor = 24'h20_30_40;

    // inclusive bounds on both axes
    typedef struct packed {
        logic [CoordWidth-1:0] xMin;
        logic [CoordWidth-1:0] xMax;
        logic [CoordWidth-1:0] yMin;
        logic [CoordWidth-1:0] yMax;
        logic [DepthWidth-1:0] depth;
        Rgb8                   color;
    } Primitive;

    typedef Primitive [LaneCount-1:0] LaneGroup;

    typedef struct packed {
        logic [CoordWidth-1:0] x;
        logic [CoordWidth-1:0] y;
    } PixelRequest;

    typedef struct packed {
        logic [CoordWidth-1:0]     x;
        logic [CoordWidth-1:0]     y;
        logic                      hit;
        logic [PrimIndexWidth-1:0] hitIndex;
        logic [DepthWidth-1:0]     hitDepth;
        Rgb8                       hitColor;
    } RasterResult;

    typedef struct packed {
        RasterResult raster;
        logic        shadow;
    } ShadowResult;

    typedef struct packed {
        logic [CoordWidth-1:0] x;
        logic [CoordWidth-1:0] y;
        Rgb8                   color;
    } ShadedPixel;

    // state set of both scan units
    typedef enum logic [1:0] {
        Idle,
        Scan,
        Done
    } ScanState;

    // point in rectangle test, bounds included
    function automatic logic covers(Primitive p, logic [CoordWidth-1:0] x,
                                    logic [CoordWidth-1:0] y);
        return (x >= p.xMin) && (x <= p.xMax) && (y >= p.yMin) && (y <= p.yMax);
    endfunction

endpackage

/* source/pipeHold.sv */
// one-entry valid/ready holding stage for any payload type
module pipeHold #(
    parameter type Payload = logic
) (
    input  logic   clk,
    input  logic   resetn,
    input  logic   inValid,
    output logic   inReady,
    input  Payload inData,
    output logic   outValid,
    input  logic   outReady,
    output Payload outData
);

    logic   full;
    Payload entry;

    // open when empty or when the entry leaves this cycle
    assign inReady  = !full || outReady;
    assign outValid = full;
    assign outData  = entry;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            full <= 1'b0;
        end else if (inReady) begin
            full <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            entry <= inData;
        end
    end

endmodule

/* source/primitiveMemory.sv */
// scene primitive store, single write port and registered read of one lane group
module primitiveMemory import rayCorePkg::*; (
    input  logic                      clk,
    input  logic                      writeValid,
    input  logic [PrimIndexWidth-1:0] writeAddr,
    input  Primitive                  writeData,
    input  logic [GroupAddrWidth-1:0] readAddr,
    output LaneGroup                  readData
);

    Primitive store [MaxPrimitives];

    always_ff @(posedge clk) begin
        if (writeValid) begin
            store[writeAddr] <= writeData;
        end
    end

    // lane l of group g sits at g * LaneCount + l
    always_ff @(posedge clk) begin
        for (int l = 0; l < LaneCount; l++) begin
            readData[l] <= store[PrimIndexWidth'(readAddr * LaneCount + l)];
        end
    end

endmodule

/* source/primitiveArbiter.sv */
// round-robin access to the primitive memory for the raster and shadow units
module primitiveArbiter import rayCorePkg::*; (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      rasterReq,
    input  logic [GroupAddrWidth-1:0] rasterAddr,
    output logic                      rasterGrant,
    input  logic                      shadowReq,
    input  logic [GroupAddrWidth-1:0] shadowAddr,
    output logic                      shadowGrant,
    output logic [GroupAddrWidth-1:0] memAddr,
    input  LaneGroup                  memData,
    output LaneGroup                  laneData,
    output logic                      rasterDataValid,
    output logic                      shadowDataValid
);

    logic lastShadow;   // who won the previous grant
    logic readPending;
    logic ownerShadow;  // owner of the read in flight

    // on contention the unit that did not win last time goes first
    assign rasterGrant = rasterReq && (!shadowReq || lastShadow);
    assign shadowGrant = shadowReq && (!rasterReq || !lastShadow);
    assign memAddr     = shadowGrant ? shadowAddr : rasterAddr;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            lastShadow  <= 1'b0;
            readPending <= 1'b0;
            ownerShadow <= 1'b0;
        end else begin
            readPending <= rasterGrant || shadowGrant;
            ownerShadow <= shadowGrant;
            if (rasterGrant || shadowGrant) begin
                lastShadow <= shadowGrant;
            end
        end
    end

    // memory data lands one cycle after the grant
    assign laneData        = memData;
    assign rasterDataValid = readPending && !ownerShadow;
    assign shadowDataValid = readPending && ownerShadow;

endmodule

/* source/closestHitUnit.sv */
// raster stage, scans every lane group and keeps the nearest covering rectangle
module closestHitUnit import rayCorePkg::*; (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      inValid,
    output logic                      inReady,
    input  PixelRequest               inData,
    input  logic [PrimCountWidth-1:0] primitiveCount,
    output logic                      memReq,
    output logic [GroupAddrWidth-1:0] memAddr,
    input  logic                      memGrant,
    input  LaneGroup                  laneData,
    input  logic                      laneValid,
    output logic                      outValid,
    input  logic                      outReady,
    output RasterResult               outData
);

    ScanState                  state;
    PixelRequest               pixel;
    logic [PrimCountWidth-1:0] issueGroup;
    logic [PrimCountWidth-1:0] recvGroup;
    logic [PrimCountWidth-1:0] numGroups;
    logic                      bestHit;
    logic [PrimIndexWidth-1:0] bestIndex;
    logic [DepthWidth-1:0]     bestDepth;
    Rgb8                       bestColor;
    logic                      nextHit;
    logic [PrimIndexWidth-1:0] nextIndex;
    logic [DepthWidth-1:0]     nextDepth;
    Rgb8                       nextColor;

    // count rounded up to whole groups
    assign numGroups = PrimCountWidth'((primitiveCount + PrimCountWidth'(LaneCount - 1))
                                       / LaneCount);

    // reads are issued ahead of the returning data
    assign memReq  = (state == Scan) && (issueGroup < numGroups);
    assign memAddr = issueGroup[GroupAddrWidth-1:0];

    // --------------------
    // lane compare, strict less keeps the lower index on a tie
    always_comb begin
        nextHit   = bestHit;
        nextIndex = bestIndex;
        nextDepth = bestDepth;
        nextColor = bestColor;
        for (int l = 0; l < LaneCount; l++) begin
            if ((PrimCountWidth'(recvGroup * LaneCount + l) < primitiveCount) &&
                covers(laneData[l], pixel.x, pixel.y) &&
                (!nextHit || (laneData[l].depth < nextDepth))) begin
                nextHit   = 1'b1;
                nextIndex = PrimIndexWidth'(recvGroup * LaneCount + l);
                nextDepth = laneData[l].depth;
                nextColor = laneData[l].color;
            end
        end
    end

    // --------------------
    // control FSM
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= Idle;
            issueGroup <= '0;
            recvGroup  <= '0;
            bestHit    <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    if (inValid) begin
                        issueGroup <= '0;
                        recvGroup  <= '0;
                        bestHit    <= 1'b0;
                        state      <= (primitiveCount == '0) ? Done : Scan;
                    end
                end
                Scan: begin
                    if (memGrant) begin
                        issueGroup <= issueGroup + 1'b1;
                    end
                    if (laneValid) begin
                        recvGroup <= recvGroup + 1'b1;
                        bestHit   <= nextHit;
                        if (recvGroup == numGroups - 1'b1) begin
                            state <= Done;
                        end
                    end
                end
                default: begin
                    if (outReady) begin
                        state <= Idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == Idle && inValid) begin
            pixel <= inData;
        end
        if (state == Scan && laneValid) begin
            bestIndex <= nextIndex;
            bestDepth <= nextDepth;
            bestColor <= nextColor;
        end
    end

    assign inReady  = (state == Idle);
    assign outValid = (state == Done);
    assign outData  = '{x: pixel.x, y: pixel.y, hit: bestHit, hitIndex: bestIndex,
                        hitDepth: bestDepth, hitColor: bestColor};

endmodule

/* source/shadowUnit.sv */
// shadow stage, any-hit scan of the light probe with exit on the first blocker
module shadowUnit import rayCorePkg::*; (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      inValid,
    output logic                      inReady,
    input  RasterResult               inData,
    input  logic [PrimCountWidth-1:0] primitiveCount,
    output logic                      memReq,
    output logic [GroupAddrWidth-1:0] memAddr,
    input  logic                      memGrant,
    input  LaneGroup                  laneData,
    input  logic                      laneValid,
    output logic                      outValid,
    input  logic                      outReady,
    output ShadowResult               outData
);

    ScanState                  state;
    RasterResult               ray;
    logic                      shadowed;
    logic [PrimCountWidth-1:0] issueGroup;
    logic [PrimCountWidth-1:0] recvGroup;
    logic [PrimCountWidth-1:0] numGroups;
    logic [CoordWidth-1:0]     probeX;
    logic [CoordWidth-1:0]     probeY;
    logic                      blockNow;

    assign numGroups = PrimCountWidth'((primitiveCount + PrimCountWidth'(LaneCount - 1))
                                       / LaneCount);
    assign probeX    = ray.x + LightDx;
    assign probeY    = ray.y + LightDy;

    assign memReq  = (state == Scan) && (issueGroup < numGroups);
    assign memAddr = issueGroup[GroupAddrWidth-1:0];

    // --------------------
    // blocker test, the hit rectangle never shadows itself
    always_comb begin
        blockNow = 1'b0;
        for (int l = 0; l < LaneCount; l++) begin
            if ((PrimCountWidth'(recvGroup * LaneCount + l) < primitiveCount) &&
                (PrimIndexWidth'(recvGroup * LaneCount + l) != ray.hitIndex) &&
                covers(laneData[l], probeX, probeY) &&
                (laneData[l].depth < ray.hitDepth)) begin
                blockNow = 1'b1;
            end
        end
    end

    // --------------------
    // control FSM
    // a read still in flight after an early exit lands in Done and is dropped
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= Idle;
            shadowed   <= 1'b0;
            issueGroup <= '0;
            recvGroup  <= '0;
        end else begin
            case (state)
                Idle: begin
                    if (inValid) begin
                        shadowed   <= 1'b0;
                        issueGroup <= '0;
                        recvGroup  <= '0;
                        // misses skip the memory entirely
                        state      <= (inData.hit && primitiveCount != '0) ? Scan : Done;
                    end
                end
                Scan: begin
                    if (memGrant) begin
                        issueGroup <= issueGroup + 1'b1;
                    end
                    if (laneValid) begin
                        recvGroup <= recvGroup + 1'b1;
                        if (blockNow) begin
                            shadowed <= 1'b1;
                            state    <= Done;
                        end else if (recvGroup == numGroups - 1'b1) begin
                            state <= Done;
                        end
                    end
                end
                default: begin
                    if (outReady) begin
                        state <= Idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == Idle && inValid) begin
            ray <= inData;
        end
    end

    assign inReady  = (state == Idle);
    assign outValid = (state == Done);
    assign outData  = '{raster: ray, shadow: shadowed};

endmodule

/* source/shadeUnit.sv */
// shade stage, clear color for misses and halved channels for shadowed hits
module shadeUnit import rayCorePkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        inValid,
    output logic        inReady,
    input  ShadowResult inData,
    output logic        outValid,
    input  logic        outReady,
    output ShadedPixel  outData
);

    Rgb8 shaded;

    always_comb begin
        if (!inData.raster.hit) begin
            shaded = ClearColor;
        end else if (inData.shadow) begin
            shaded.r = inData.raster.hitColor.r >> 1;
            shaded.g = inData.raster.hitColor.g >> 1;
            shaded.b = inData.raster.hitColor.b >> 1;
        end else begin
            shaded = inData.raster.hitColor;
        end
    end

    assign inReady = !outValid || outReady;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outData <= '{x: inData.raster.x, y: inData.raster.y, color: shaded};
        end
    end

endmodule

/* source/rayCoreTop.sv */
// ray core top, raster to shadow to shade pipeline over one shared primitive memory
module rayCoreTop import rayCorePkg::*; (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      sceneWriteValid,
    input  logic [PrimIndexWidth-1:0] sceneWriteAddr,
    input  Primitive                  sceneWriteData,
    input  logic [PrimCountWidth-1:0] primitiveCount,
    input  logic                      inValid,
    output logic                      inReady,
    input  PixelRequest               inData,
    output logic                      outValid,
    input  logic                      outReady,
    output ShadedPixel                outData
);

    // --------------------
    // stream wires
    logic        pixValid, pixReady;
    PixelRequest pixData;
    logic        rasValid, rasReady, rasHoldValid, rasHoldReady;
    RasterResult rasData, rasHoldData;
    logic        shdValid, shdReady, shdHoldValid, shdHoldReady;
    ShadowResult shdData, shdHoldData;

    // memory side
    logic                      rasterReq, rasterGrant, rasterDataValid;
    logic                      shadowReq, shadowGrant, shadowDataValid;
    logic [GroupAddrWidth-1:0] rasterAddr, shadowAddr, memAddr;
    LaneGroup                  memData, laneData;

    pipeHold #(.Payload(PixelRequest)) pixelHold (
        .clk(clk), .resetn(resetn),
        .inValid(inValid), .inReady(inReady), .inData(inData),
        .outValid(pixValid), .outReady(pixReady), .outData(pixData)
    );

    closestHitUnit raster (
        .clk(clk), .resetn(resetn),
        .inValid(pixValid), .inReady(pixReady), .inData(pixData),
        .primitiveCount(primitiveCount),
        .memReq(rasterReq), .memAddr(rasterAddr), .memGrant(rasterGrant),
        .laneData(laneData), .laneValid(rasterDataValid),
        .outValid(rasValid), .outReady(rasReady), .outData(rasData)
    );

    pipeHold #(.Payload(RasterResult)) rasterHold (
        .clk(clk), .resetn(resetn),
        .inValid(rasValid), .inReady(rasReady), .inData(rasData),
        .outValid(rasHoldValid), .outReady(rasHoldReady), .outData(rasHoldData)
    );

    shadowUnit shadow (
        .clk(clk), .resetn(resetn),
        .inValid(rasHoldValid), .inReady(rasHoldReady), .inData(rasHoldData),
        .primitiveCount(primitiveCount),
        .memReq(shadowReq), .memAddr(shadowAddr), .memGrant(shadowGrant),
        .laneData(laneData), .laneValid(shadowDataValid),
        .outValid(shdValid), .outReady(shdReady), .outData(shdData)
    );

    pipeHold #(.Payload(ShadowResult)) shadowHold (
        .clk(clk), .resetn(resetn),
        .inValid(shdValid), .inReady(shdReady), .inData(shdData),
        .outValid(shdHoldValid), .outReady(shdHoldReady), .outData(shdHoldData)
    );

    shadeUnit shade (
        .clk(clk), .resetn(resetn),
        .inValid(shdHoldValid), .inReady(shdHoldReady), .inData(shdHoldData),
        .outValid(outValid), .outReady(outReady), .outData(outData)
    );

    primitiveArbiter arbiter (
        .clk(clk), .resetn(resetn),
        .rasterReq(rasterReq), .rasterAddr(rasterAddr), .rasterGrant(rasterGrant),
        .shadowReq(shadowReq), .shadowAddr(shadowAddr), .shadowGrant(shadowGrant),
        .memAddr(memAddr), .memData(memData), .laneData(laneData),
        .rasterDataValid(rasterDataValid), .shadowDataValid(shadowDataValid)
    );

    primitiveMemory memory (
        .clk(clk),
        .writeValid(sceneWriteValid), .writeAddr(sceneWriteAddr),
        .writeData(sceneWriteData),
        .readAddr(memAddr), .readData(memData)
    );

endmodule

/* testbench/rayCore_sva.sv */
// handshake, arbitration and reset checks for the ray core, bound into the top level
module rayCoreSva import rayCorePkg::*; (
    input logic       clk,
    input logic       resetn,
    input logic       outValid,
    input logic       outReady,
    input ShadedPixel outData,
    input logic       pixValid,
    input logic       rasHoldValid,
    input logic       shdHoldValid,
    input logic       rasterReq,
    input logic       rasterGrant,
    input logic       rasterDataValid,
    input logic       shadowReq,
    input logic       shadowGrant,
    input logic       shadowDataValid
);
    timeunit 1ns;
    timeprecision 100ps;

    int   failCount = 0;
    logic rasterWaiting;
    logic shadowWaiting;

    // request up but lost to the other unit
    assign rasterWaiting = rasterReq && !rasterGrant;
    assign shadowWaiting = shadowReq && !shadowGrant;

    // --------------------
    // output stream
    assert property (@(posedge clk) disable iff (!resetn)
            outValid && !outReady |=> outValid && $stable(outData))
        else begin
            failCount++;
            $error("outData or outValid moved while outReady was low");
        end

    // --------------------
    // arbitration
    assert property (@(posedge clk) disable iff (!resetn)
            (!rasterGrant || rasterReq) && (!shadowGrant || shadowReq))
        else begin
            failCount++;
            $error("memory grant given with no request");
        end

    assert property (@(posedge clk) disable iff (!resetn) !(rasterGrant && shadowGrant))
        else begin
            failCount++;
            $error("raster and shadow grants high together");
        end

    // a held request waits two cycles at most
    assert property (@(posedge clk) disable iff (!resetn)
            !(rasterWaiting && $past(rasterWaiting) && $past(rasterWaiting, 2)) &&
            !(shadowWaiting && $past(shadowWaiting) && $past(shadowWaiting, 2)))
        else begin
            failCount++;
            $error("request left waiting longer than two cycles");
        end

    assert property (@(posedge clk) disable iff (!resetn)
            rasterDataValid == $past(rasterGrant) && shadowDataValid == $past(shadowGrant))
        else begin
            failCount++;
            $error("lane data valid not one cycle after its grant");
        end

    // --------------------
    // reset
    assert property (@(posedge clk) (!resetn || $rose(resetn)) |->
            !outValid && !pixValid && !rasHoldValid && !shdHoldValid &&
            !rasterGrant && !shadowGrant)
        else begin
            failCount++;
            $error("valid or grant high during or right after reset");
        end

endmodule

bind rayCoreTop rayCoreSva sva_i (.*);

/* testbench/rayCoreTb.sv */
// ray core testbench, loads scenes, streams pixels and scores the shaded output
module rayCoreTb import rayCorePkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          ResetCycles  = 5;
    localparam int          DirectCount  = 12;
    localparam int          RandomCount  = 48;
    localparam int          LoadCycles   = 2 * MaxPrimitives + 8;
    localparam int          CycleLimit   = (DirectCount + RandomCount) * (MaxPrimitives + 20)
                                           + ResetCycles + LoadCycles;
    localparam logic [31:0] Seed         = 32'd77741;
    // x in the high byte, y in the low byte
    localparam logic [15:0] DirectPixels [DirectCount] = '{
        16'h1616, 16'h1C1C, 16'h2D2D, 16'h1212, 16'h2627, 16'h2F26,
        16'h0505, 16'h9696, 16'h3C3C, 16'h0A0A, 16'h6969, 16'h7778
    };

    logic                      clk;
    logic                      resetn;
    logic                      sceneWriteValid;
    logic [PrimIndexWidth-1:0] sceneWriteAddr;
    Primitive                  sceneWriteData;
    logic [PrimCountWidth-1:0] primitiveCount;
    logic                      inValid;
    logic                      inReady;
    PixelRequest               inData;
    logic                      outValid;
    logic                      outReady;
    ShadedPixel                outData;

    Primitive    scene [MaxPrimitives];
    int          sceneCount = 0;
    ShadedPixel  expectQ [$];
    int          errorCount = 0;
    int          cycleCount = 0;
    bit          randomReady = 1'b0;
    logic [31:0] stimRng = Seed;
    logic [31:0] readyRng = Seed;

    rayCoreTop dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------
    // reference model
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic bit pointInside(input Primitive p, input logic [7:0] x,
                                       input logic [7:0] y);
        return x >= p.xMin && x <= p.xMax && y >= p.yMin && y <= p.yMax;
    endfunction

    function automatic ShadedPixel expectedPixel(input PixelRequest p);
        ShadedPixel res;
        int         best;
        bit         shadowed;
        logic [7:0] probeX;
        logic [7:0] probeY;
        best     = -1;
        shadowed = 1'b0;
        probeX   = p.x + LightDx;
        probeY   = p.y + LightDy;
        // nearest wins, first index on equal depth
        for (int i = 0; i < sceneCount; i++) begin
            if (pointInside(scene[i], p.x, p.y) &&
                (best < 0 || scene[i].depth < scene[best].depth)) begin
                best = i;
            end
        end
        res.x = p.x;
        res.y = p.y;
        if (best < 0) begin
            res.color = ClearColor;
        end else begin
            for (int i = 0; i < sceneCount; i++) begin
                if (i != best && pointInside(scene[i], probeX, probeY) &&
                    scene[i].depth < scene[best].depth) begin
                    shadowed = 1'b1;
                end
            end
            res.color = scene[best].color;
            if (shadowed) begin
                res.color.r = scene[best].color.r >> 1;
                res.color.g = scene[best].color.g >> 1;
                res.color.b = scene[best].color.b >> 1;
            end
        end
        return res;
    endfunction

    // --------------------
    // stimulus helpers
    task automatic writePrimitive(input int idx, input Primitive p);
        sceneWriteValid = 1'b1;
        sceneWriteAddr  = PrimIndexWidth'(idx);
        sceneWriteData  = p;
        scene[idx]      = p;
        @(posedge clk);
        #2;
        sceneWriteValid = 1'b0;
    endtask

    task automatic placeRect(input int idx, input logic [7:0] x0, input logic [7:0] x1,
                             input logic [7:0] y0, input logic [7:0] y1,
                             input logic [7:0] depth, input logic [23:0] color);
        Primitive p;
        p.xMin  = x0;
        p.xMax  = x1;
        p.yMin  = y0;
        p.yMax  = y1;
        p.depth = depth;
        p.color = color;
        writePrimitive(idx, p);
    endtask

    // ready is sampled mid cycle, where it is settled for the next edge
    task automatic sendPixel(input PixelRequest p);
        bit taken;
        inValid = 1'b1;
        inData  = p;
        do begin
            @(negedge clk);
            taken = inReady;
            @(posedge clk);
        end while (!taken);
        #2;
        inValid = 1'b0;
    endtask

    task automatic drainResults();
        while (expectQ.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    // outReady gaps, own generator so stimulus order stays fixed
    always @(posedge clk) begin : readyDriver
        bit gapsNow;
        gapsNow = randomReady;
        #2;
        readyRng = xorshift(readyRng);
        outReady = gapsNow ? (readyRng[1:0] != 2'b00) : 1'b1;
    end

    // --------------------
    // scoreboard
    always @(posedge clk) begin : scoreboard
        ShadedPixel want;
        if (resetn && inValid && inReady) begin
            expectQ.push_back(expectedPixel(inData));
        end
        if (resetn && outValid && outReady) begin
            assert (expectQ.size() != 0) else begin
                errorCount++;
                $display("output pixel at x %0d y %0d came with no pixel pending",
                         outData.x, outData.y);
            end
            if (expectQ.size() != 0) begin
                want = expectQ.pop_front();
                assert (outData == want) else begin
                    errorCount++;
                    $display("ERR outData expected %h got %h", want, outData);
                end
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("run stopped after %0d cycles with %0d results still missing",
                     cycleCount, expectQ.size());
            $display("errors: scoreboard %0d, assertions %0d", errorCount,
                     dut_i.sva_i.failCount);
            $display("Test failed");
            $finish;
        end
    end

    initial begin : stimulus
        Primitive    p;
        PixelRequest px;
        logic [31:0] a;
        resetn          = 1'b1;
        sceneWriteValid = 1'b0;
        sceneWriteAddr  = '0;
        sceneWriteData  = '0;
        primitiveCount  = '0;
        inValid         = 1'b0;
        inData          = '0;
        outReady        = 1'b1;
        #1 resetn = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #2 resetn = 1'b1;

        // hand placed scene, index 5 sits in the padded lane
        placeRect(0, 8'd10, 8'd60, 8'd10, 8'd60, 8'd100, 24'hC0_80_40);
        placeRect(1, 8'd20, 8'd30, 8'd20, 8'd30, 8'd50, 24'h80_F0_10);
        placeRect(2, 8'd20, 8'd30, 8'd20, 8'd30, 8'd50, 24'h11_22_33);
        placeRect(3, 8'd40, 8'd50, 8'd40, 8'd50, 8'd30, 24'hAA_BB_CC);
        placeRect(4, 8'd100, 8'd120, 8'd100, 8'd120, 8'd10, 24'h50_60_70);
        placeRect(5, 8'd0, 8'd200, 8'd0, 8'd200, 8'd1, 24'hFF_00_FF);
        for (int k = 6; k < MaxPrimitives; k++) begin
            writePrimitive(k, '0);
        end
        sceneCount     = 5;
        primitiveCount = PrimCountWidth'(sceneCount);
        for (int k = 0; k < DirectCount; k++) begin
            sendPixel(DirectPixels[k]);
        end
        drainResults();

        // --------------------
        // random scene with stalls on the output
        for (int k = 0; k < MaxPrimitives; k++) begin
            stimRng = xorshift(stimRng);
            a       = stimRng;
            p.xMin  = {2'b00, a[5:0]};
            p.xMax  = p.xMin + {4'b0000, a[9:6]} + 8'd2;
            p.yMin  = {2'b00, a[15:10]};
            p.yMax  = p.yMin + {4'b0000, a[19:16]} + 8'd2;
            p.depth = {4'b0000, a[23:20]};
            stimRng = xorshift(stimRng);
            p.color = stimRng[23:0];
            writePrimitive(k, p);
        end
        stimRng        = xorshift(stimRng);
        sceneCount     = 9 + int'(stimRng[2:0]);
        primitiveCount = PrimCountWidth'(sceneCount);
        randomReady    = 1'b1;
        for (int k = 0; k < RandomCount; k++) begin
            stimRng = xorshift(stimRng);
            a       = stimRng;
            px.x    = {2'b00, a[5:0]};
            px.y    = {2'b00, a[13:8]};
            if (a[19:17] == 3'b000) begin
                @(posedge clk);
                #2;
            end
            sendPixel(px);
        end
        drainResults();
        randomReady = 1'b0;
        repeat (3) @(posedge clk);

        $display("errors: scoreboard %0d, assertions %0d", errorCount, dut_i.sva_i.failCount);
        if (errorCount == 0 && dut_i.sva_i.failCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
source/rayCorePkg.sv
source/pipeHold.sv
source/primitiveMemory.sv
source/primitiveArbiter.sv
source/closestHitUnit.sv
source/shadowUnit.sv
source/shadeUnit.sv
source/rayCoreTop.sv
testbench/rayCore_sva.sv
testbench/rayCoreTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert --timescale 1ns/100ps
TOP       = rayCoreTb
FILELIST  = vlog.f
BUILD     = obj_dir
RUNFLAGS  = +verilator+error+limit+1000
PASSLINE  = Test passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	@out="$$(./$(BUILD)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSLINE)"

clean:
	rm -rf $(BUILD)
